//--- sim.f
+incdir+include
verilog/pipePkg.sv
verilog/issueBuffer.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/forwardUnit.sv
verilog/aluExecute.sv
verilog/aluPipeline.sv
verification/pipeTb.sv

//--- Makefile
# Verilator build and run of the ALU pipeline testbench

SRCS := $(shell grep -v '^+' sim.f)

run: obj_dir/VpipeTb
	@out=$$(./obj_dir/VpipeTb); echo "$$out"; echo "$$out" | grep -qx "test passed"

# rebuilt only when a source, the header or the file list changes
obj_dir/VpipeTb: sim.f $(SRCS) $(wildcard include/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module pipeTb -f sim.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- verification/pipeTb.sv
/*
 * Testbench for the ALU pipeline. Sends directed and random instructions
 * under credit flow control, keeps a reference register model and checks
 * write-backs, credits, halt and latency with assertions.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module pipeTb;
    localparam int MaxWrites = 1024;
    localparam int NumRandom = 300;

    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2A;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opOri  = 6'h0D;
    localparam logic [5:0] opLui  = 6'h0F;
    localparam logic [5:0] opNone = 6'h3F;  // unused opcode that retires silently

    logic                    clk;
    logic                    rstN;
    logic                    instValid;
    pipePkg::instWord_t      instWord;
    logic                    halt;
    logic                    creditReturn;
    pipePkg::wbInfo_t        wbOut;

    logic [`PIPE_DATA_W-1:0] refRegs [`PIPE_NUM_REGS];
    logic [`PIPE_REG_AW-1:0] expDst [MaxWrites];
    logic [`PIPE_DATA_W-1:0] expData [MaxWrites];
    int                      expCycle [MaxWrites];  // -1 when not timed
    int                      pushIdx;
    int                      popIdx;
    int                      sentCount;
    int                      returnCount;
    int                      credits;
    int                      cycle;
    int                      haltRun;     // consecutive edges with halt high
    int                      errCount;
    int                      seed;
    bit                      haltRandom;

    aluPipeline dut_i (
        .clk          (clk),
        .rstN         (rstN),
        .instValid    (instValid),
        .instWord     (instWord),
        .halt         (halt),
        .creditReturn (creditReturn),
        .wbOut        (wbOut)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assign credits = `PIPE_ISSUE_DEPTH - sentCount + returnCount;

    always @(posedge clk) begin
        cycle   <= cycle + 1;
        haltRun <= halt ? haltRun + 1 : 0;
        if (rstN && creditReturn) returnCount <= returnCount + 1;
        if (rstN && wbOut.valid) popIdx <= popIdx + 1;  // consume one expected write
    end

    // watchdog budget grows with every instruction sent
    always @(posedge clk) begin
        if (cycle > sentCount * 20 + 1000) begin
            $display("timeout: pipeline stopped making progress at cycle %0d", cycle);
            $display("test failed");
            $finish;
        end
    end

    wbOrder: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.valid |-> (popIdx < pushIdx && wbOut.wrEn && wbOut.dst != '0))
        else begin
            $display("unexpected write-back to r%0d", $sampled(wbOut.dst));
            errCount++;
        end

    wbDst: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.valid |-> wbOut.dst == expDst[popIdx])
        else begin
            $display("Mismatch wbOut.dst expected %h got %h",
                     $sampled(expDst[popIdx]), $sampled(wbOut.dst));
            errCount++;
        end

    wbData: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.valid |-> wbOut.data == expData[popIdx])
        else begin
            $display("Mismatch wbOut.data expected %h got %h",
                     $sampled(expData[popIdx]), $sampled(wbOut.data));
            errCount++;
        end

    wbLatency: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.valid && popIdx < pushIdx && expCycle[popIdx] >= 0)
            |-> cycle == expCycle[popIdx])
        else begin
            $display("Mismatch wbOut.valid cycle expected %h got %h",
                     $sampled(expCycle[popIdx]), $sampled(cycle));
            errCount++;
        end

    creditRange: assert property (@(posedge clk) disable iff (!rstN)
        credits >= 0 && credits <= `PIPE_ISSUE_DEPTH)
        else begin
            $display("sender credit count left its range: %0d", $sampled(credits));
            errCount++;
        end

    haltDrain: assert property (@(posedge clk) disable iff (!rstN)
        haltRun >= 3 |-> !wbOut.valid)
        else begin
            $display("write-back still active %0d cycles into halt", $sampled(haltRun));
            errCount++;
        end

    haltCredit: assert property (@(posedge clk) disable iff (!rstN)
        haltRun >= 1 |-> !creditReturn)
        else begin
            $display("credit returned while halt was high");
            errCount++;
        end

    function automatic pipePkg::instWord_t rInst(input logic [5:0] fn,
                                                 input logic [4:0] rd,
                                                 input logic [4:0] rs,
                                                 input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic pipePkg::instWord_t iInst(input logic [5:0] op,
                                                 input logic [4:0] rt,
                                                 input logic [4:0] rs,
                                                 input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model run in program order at send time
    task automatic refStep(input pipePkg::instWord_t w, input bit timed);
        logic [31:0]             bits;
        logic [4:0]              dst;
        logic [`PIPE_DATA_W-1:0] a;
        logic [`PIPE_DATA_W-1:0] b;
        logic [`PIPE_DATA_W-1:0] res;
        bit                      known;
        bits  = w;
        a     = refRegs[bits[25:21]];
        b     = refRegs[bits[20:16]];
        known = 1'b1;
        res   = '0;
        if (bits[31:26] == 6'h00) begin
            dst = bits[15:11];
            case (bits[5:0])
                fnAdd:   res = a + b;
                fnSub:   res = a - b;
                fnAnd:   res = a & b;
                fnOr:    res = a | b;
                fnXor:   res = a ^ b;
                fnSlt:   res = ($signed(a) < $signed(b)) ? 1 : 0;
                default: known = 1'b0;
            endcase
        end else begin
            dst = bits[20:16];
            case (bits[31:26])
                opAddi:  res = a + {{16{bits[15]}}, bits[15:0]};
                opOri:   res = a | {16'h0000, bits[15:0]};
                opLui:   res = {bits[15:0], 16'h0000};
                default: known = 1'b0;
            endcase
        end
        if (known && dst != 5'd0) begin
            refRegs[dst]      = res;
            expDst[pushIdx]   = dst;
            expData[pushIdx]  = res;
            expCycle[pushIdx] = timed ? cycle + 4 : -1;  // seen on the 4th edge
            pushIdx++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        if (haltRandom && (($random(seed) & 7) == 0)) halt = !halt;
    endtask

    task automatic sendInst(input pipePkg::instWord_t w, input bit timed = 1'b0);
        while (credits <= 0) tick();
        instValid = 1'b1;
        instWord  = w;
        sentCount++;
        refStep(w, timed);
        tick();
        instValid = 1'b0;
    endtask

    // buffer empty and every expected write retired
    task automatic waitDrain();
        haltRandom = 1'b0;
        halt       = 1'b0;
        while (credits != `PIPE_ISSUE_DEPTH || popIdx != pushIdx) tick();
    endtask

    task automatic makeRandom(output pipePkg::instWord_t w);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        kind = int'($unsigned($random(seed)) % 10);
        rd   = 5'($random(seed) & 7);  // r0..r7 keeps dependencies dense
        rs   = 5'($random(seed) & 7);
        rt   = 5'($random(seed) & 7);
        imm  = 16'($random(seed));
        case (kind)
            0:       w = rInst(fnAdd, rd, rs, rt);
            1:       w = rInst(fnSub, rd, rs, rt);
            2:       w = rInst(fnAnd, rd, rs, rt);
            3:       w = rInst(fnOr, rd, rs, rt);
            4:       w = rInst(fnXor, rd, rs, rt);
            5:       w = rInst(fnSlt, rd, rs, rt);
            6:       w = iInst(opAddi, rd, rs, imm);
            7:       w = iInst(opOri, rd, rs, imm);
            8:       w = iInst(opLui, rd, rs, imm);
            default: w = iInst(opNone, rd, rs, imm);
        endcase
    endtask

    initial begin
        pipePkg::instWord_t w;
        rstN       = 1'b0;
        instValid  = 1'b0;
        instWord   = '0;
        halt       = 1'b0;
        haltRandom = 1'b0;
        seed       = 32'he673;
        pushIdx    = 0;
        popIdx     = 0;
        sentCount  = 0;
        returnCount = 0;
        cycle      = 0;
        haltRun    = 0;
        errCount   = 0;
        for (int i = 0; i < `PIPE_NUM_REGS; i++) refRegs[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        tick();

        // operand setup, then independent R-type ops
        sendInst(iInst(opOri, 5'd1, 5'd0, 16'h00F0));
        sendInst(iInst(opOri, 5'd2, 5'd0, 16'h0F0F));
        sendInst(iInst(opAddi, 5'd3, 5'd0, 16'hFFFB));  // -5
        sendInst(iInst(opLui, 5'd4, 5'd0, 16'h8001));
        waitDrain();
        sendInst(rInst(fnAdd, 5'd5, 5'd1, 5'd2));
        sendInst(rInst(fnSub, 5'd6, 5'd3, 5'd4));
        sendInst(rInst(fnAnd, 5'd7, 5'd1, 5'd2));
        sendInst(rInst(fnOr, 5'd8, 5'd1, 5'd4));
        sendInst(rInst(fnXor, 5'd9, 5'd2, 5'd3));
        sendInst(rInst(fnSlt, 5'd10, 5'd3, 5'd1));  // signed compare
        sendInst(rInst(fnSlt, 5'd11, 5'd1, 5'd4));
        sendInst(iInst(opAddi, 5'd12, 5'd4, 16'h7FFF));
        waitDrain();

        // consumer at distance 1, 2 and 3 from its producer
        sendInst(iInst(opAddi, 5'd20, 5'd0, 16'h0011));
        sendInst(rInst(fnAdd, 5'd21, 5'd20, 5'd20));
        sendInst(iInst(opAddi, 5'd22, 5'd0, 16'h0022));
        sendInst(iInst(opNone, 5'd0, 5'd0, 16'h0000));
        sendInst(rInst(fnSub, 5'd23, 5'd22, 5'd1));
        sendInst(iInst(opAddi, 5'd24, 5'd0, 16'h0033));
        sendInst(iInst(opNone, 5'd0, 5'd0, 16'h0000));
        sendInst(rInst(6'h3F, 5'd25, 5'd1, 5'd1));  // undefined funct
        sendInst(rInst(fnOr, 5'd25, 5'd24, 5'd2));
        // newer of two in-flight r26 writers wins
        sendInst(iInst(opAddi, 5'd26, 5'd0, 16'h0001));
        sendInst(iInst(opAddi, 5'd26, 5'd0, 16'h0002));
        sendInst(rInst(fnAdd, 5'd27, 5'd26, 5'd26));
        sendInst(iInst(opAddi, 5'd0, 5'd0, 16'h0055));
        sendInst(rInst(fnAdd, 5'd0, 5'd1, 5'd2));
        sendInst(rInst(fnOr, 5'd28, 5'd0, 5'd0));  // r0 reads as zero
        waitDrain();

        repeat (4) tick();
        sendInst(iInst(opOri, 5'd31, 5'd0, 16'hABCD), 1'b1);
        waitDrain();

        // fill the buffer under halt
        halt = 1'b1;
        repeat (`PIPE_ISSUE_DEPTH) sendInst(rInst(fnAdd, 5'd29, 5'd29, 5'd1));
        repeat (12) tick();
        halt = 1'b0;
        waitDrain();

        haltRandom = 1'b1;
        repeat (NumRandom) begin
            makeRandom(w);
            if (($random(seed) & 3) == 0) tick();
            sendInst(w);
        end
        waitDrain();
        repeat (8) tick();

        creditTotal: assert (returnCount == sentCount)
            else begin
                $display("Mismatch creditReturn count expected %h got %h",
                         sentCount, returnCount);
                errCount++;
            end

        $display("errors %0d, writes checked %0d, instructions sent %0d",
                 errCount, popIdx, sentCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog/aluPipeline.sv
/*
 * Top of the four-stage ALU pipeline: issue FIFO, decode, register file,
 * forwarding and execute. Instructions enter under credit flow control
 * and every retired register write shows up on wbOut.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module aluPipeline (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instValid,
    input  pipePkg::instWord_t instWord,
    input  logic               halt,
    output logic               creditReturn,
    output pipePkg::wbInfo_t   wbOut
);
    logic                    headValid;
    pipePkg::instWord_t      headWord;
    logic                    deq;
    logic [`PIPE_REG_AW-1:0] rsAddr;
    logic [`PIPE_REG_AW-1:0] rtAddr;
    logic [`PIPE_DATA_W-1:0] rsData;
    logic [`PIPE_DATA_W-1:0] rtData;
    pipePkg::exeStage_t      exeStage;
    pipePkg::wbInfo_t        memStage;
    pipePkg::wbInfo_t        wbStage;
    pipePkg::fwdSel_t        fwdA;
    pipePkg::fwdSel_t        fwdB;

    issueBuffer issueBuffer_i (
        .clk          (clk),
        .rstN         (rstN),
        .instValid    (instValid),
        .instWord     (instWord),
        .deq          (deq),
        .headValid    (headValid),
        .headWord     (headWord),
        .creditReturn (creditReturn)
    );

    decodeStage decodeStage_i (
        .clk       (clk),
        .rstN      (rstN),
        .headValid (headValid),
        .headWord  (headWord),
        .halt      (halt),
        .deq       (deq),
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .rsData    (rsData),
        .rtData    (rtData),
        .exeStage  (exeStage)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rsAddr),
        .rdAddrB (rtAddr),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .wrPort  (wbStage)   // write-back commits here
    );

    forwardUnit forwardUnit_i (
        .exeStage (exeStage),
        .memStage (memStage),
        .wbStage  (wbStage),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

    aluExecute aluExecute_i (
        .clk      (clk),
        .rstN     (rstN),
        .exeStage (exeStage),
        .fwdA     (fwdA),
        .fwdB     (fwdB),
        .memStage (memStage),
        .wbStage  (wbStage)
    );

    assign wbOut = wbStage;  // valid only for real writes

endmodule

//--- verilog/aluExecute.sv
/*
 * Execute stage. Resolves forwarded operands, runs the ALU and carries
 * the result through the memory and write-back registers.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module aluExecute (
    input  logic               clk,
    input  logic               rstN,
    input  pipePkg::exeStage_t exeStage,
    input  pipePkg::fwdSel_t   fwdA,
    input  pipePkg::fwdSel_t   fwdB,
    output pipePkg::wbInfo_t   memStage,
    output pipePkg::wbInfo_t   wbStage
);
    logic [`PIPE_DATA_W-1:0] opA;
    logic [`PIPE_DATA_W-1:0] rtVal;  // forwarded rt before the immediate mux
    logic [`PIPE_DATA_W-1:0] opB;
    logic [`PIPE_DATA_W-1:0] result;

    function automatic logic [`PIPE_DATA_W-1:0] pickOperand(
        input pipePkg::fwdSel_t        sel,
        input logic [`PIPE_DATA_W-1:0] regData,
        input logic [`PIPE_DATA_W-1:0] memData,
        input logic [`PIPE_DATA_W-1:0] wbData
    );
        case (sel)
            pipePkg::fromMem: return memData;
            pipePkg::fromWb:  return wbData;
            default:          return regData;
        endcase
    endfunction

    assign opA   = pickOperand(fwdA, exeStage.rsData, memStage.data, wbStage.data);
    assign rtVal = pickOperand(fwdB, exeStage.rtData, memStage.data, wbStage.data);
    assign opB   = exeStage.useImm ? exeStage.imm : rtVal;

    always_comb begin
        case (exeStage.aluOp)
            pipePkg::aluSub: result = opA - opB;  // wraps
            pipePkg::aluAnd: result = opA & opB;
            pipePkg::aluOr:  result = opA | opB;
            pipePkg::aluXor: result = opA ^ opB;
            pipePkg::aluSlt: result = `PIPE_DATA_W'($signed(opA) < $signed(opB));
            pipePkg::aluLui: result = opB;  // immediate arrives pre-shifted
            default:         result = opA + opB;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memStage <= '0;
            wbStage  <= '0;
        end else begin
            memStage.valid <= exeStage.valid && exeStage.wrEn;
            memStage.wrEn  <= exeStage.valid && exeStage.wrEn;
            memStage.dst   <= exeStage.dst;
            memStage.data  <= result;
            wbStage        <= memStage;  // no memory access in this design
        end
    end

endmodule

//--- verilog/forwardUnit.sv
/*
 * Operand source selection for the execute stage.
 * Compares rs and rt against the memory and write-back destinations;
 * the memory stage holds the newer result and wins a tie.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module forwardUnit (
    input  pipePkg::exeStage_t exeStage,
    input  pipePkg::wbInfo_t   memStage,
    input  pipePkg::wbInfo_t   wbStage,
    output pipePkg::fwdSel_t   fwdA,
    output pipePkg::fwdSel_t   fwdB
);

    // one source register against both producers
    function automatic pipePkg::fwdSel_t pickSource(
        input logic [`PIPE_REG_AW-1:0] src,
        input pipePkg::wbInfo_t        memInfo,
        input pipePkg::wbInfo_t        wbInfo
    );
        logic memHit;
        logic wbHit;
        memHit = memInfo.valid && memInfo.wrEn && (memInfo.dst == src);
        wbHit  = wbInfo.valid && wbInfo.wrEn && (wbInfo.dst == src);
        if (memHit) begin
            return pipePkg::fromMem;
        end else if (wbHit) begin
            return pipePkg::fromWb;
        end
        return pipePkg::regFile;
    endfunction

    // one select per source operand
    always_comb begin
        fwdA = pickSource(exeStage.rs, memStage, wbStage);
        fwdB = pickSource(exeStage.rt, memStage, wbStage);
    end

endmodule

//--- verilog/decodeStage.sv
/*
 * Decode of the FIFO head. Issues when the head is valid and halt is low,
 * reads both operands and loads the execute register; bubbles otherwise.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module decodeStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    headValid,
    input  pipePkg::instWord_t      headWord,
    input  logic                    halt,
    output logic                    deq,
    output logic [`PIPE_REG_AW-1:0] rsAddr,
    output logic [`PIPE_REG_AW-1:0] rtAddr,
    input  logic [`PIPE_DATA_W-1:0] rsData,
    input  logic [`PIPE_DATA_W-1:0] rtData,
    output pipePkg::exeStage_t      exeStage
);
    pipePkg::exeStage_t  nextStage;
    logic                legal;  // recognised encoding

    assign deq    = headValid && !halt;
    assign rsAddr = headWord.rType.rs;  // rs/rt sit in the same bits for both formats
    assign rtAddr = headWord.rType.rt;

    always_comb begin
        legal            = 1'b0;
        nextStage        = '0;
        nextStage.valid  = 1'b1;
        nextStage.rs     = headWord.rType.rs;
        nextStage.rt     = headWord.rType.rt;
        nextStage.rsData = rsData;
        nextStage.rtData = rtData;
        nextStage.aluOp  = pipePkg::aluAdd;
        if (headWord.rType.opcode == pipePkg::opRType) begin
            nextStage.dst = headWord.rType.rd;
            legal         = 1'b1;
            case (headWord.rType.funct)
                pipePkg::fnAdd: nextStage.aluOp = pipePkg::aluAdd;
                pipePkg::fnSub: nextStage.aluOp = pipePkg::aluSub;
                pipePkg::fnAnd: nextStage.aluOp = pipePkg::aluAnd;
                pipePkg::fnOr:  nextStage.aluOp = pipePkg::aluOr;
                pipePkg::fnXor: nextStage.aluOp = pipePkg::aluXor;
                pipePkg::fnSlt: nextStage.aluOp = pipePkg::aluSlt;
                default:        legal = 1'b0;
            endcase
        end else begin
            nextStage.dst    = headWord.iType.rt;  // I-type writes rt
            nextStage.useImm = 1'b1;
            case (headWord.iType.opcode)
                pipePkg::opAddi: begin
                    legal           = 1'b1;
                    nextStage.aluOp = pipePkg::aluAdd;
                    nextStage.imm   = {{(`PIPE_DATA_W-16){headWord.iType.imm[15]}},
                                       headWord.iType.imm};
                end
                pipePkg::opOri: begin
                    legal           = 1'b1;
                    nextStage.aluOp = pipePkg::aluOr;
                    nextStage.imm   = `PIPE_DATA_W'(headWord.iType.imm);
                end
                pipePkg::opLui: begin
                    legal           = 1'b1;
                    nextStage.aluOp = pipePkg::aluLui;
                    nextStage.imm   = `PIPE_DATA_W'({headWord.iType.imm, 16'h0000});
                end
                default: legal = 1'b0;
            endcase
        end
        // no-ops and r0 targets retire silently
        nextStage.wrEn = legal && (nextStage.dst != '0);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeStage <= '0;
        end else if (deq) begin
            exeStage <= nextStage;
        end else begin
            exeStage <= '0;  // bubble
        end
    end

endmodule

//--- verilog/regFile.sv
/*
 * Architectural register file, two read ports and one write port.
 * A read of the address being written returns the new data that cycle.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`PIPE_REG_AW-1:0] rdAddrA,
    input  logic [`PIPE_REG_AW-1:0] rdAddrB,
    output logic [`PIPE_DATA_W-1:0] rdDataA,
    output logic [`PIPE_DATA_W-1:0] rdDataB,
    input  pipePkg::wbInfo_t        wrPort
);
    logic [`PIPE_DATA_W-1:0] regs [`PIPE_NUM_REGS];
    logic                    wrHit;

    assign wrHit = wrPort.valid && wrPort.wrEn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `PIPE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrHit) begin
            regs[wrPort.dst] <= wrPort.data;  // r0 never arrives with wrEn
        end
    end

    // write-to-read bypass
    assign rdDataA = (wrHit && wrPort.dst == rdAddrA) ? wrPort.data : regs[rdAddrA];
    assign rdDataB = (wrHit && wrPort.dst == rdAddrB) ? wrPort.data : regs[rdAddrB];

endmodule

//--- verilog/issueBuffer.sv
/*
 * Instruction FIFO between the credit-based sender and decode.
 * Every dequeue hands one credit back on creditReturn a cycle later.
 */
`timescale 1ns/1ns
`include "pipe_config.svh"

module issueBuffer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instValid,
    input  pipePkg::instWord_t  instWord,
    input  logic                deq,
    output logic                headValid,
    output pipePkg::instWord_t  headWord,
    output logic                creditReturn
);
    localparam int PtrW = (`PIPE_ISSUE_DEPTH > 1) ? $clog2(`PIPE_ISSUE_DEPTH) : 1;
    localparam int CntW = $clog2(`PIPE_ISSUE_DEPTH + 1);

    pipePkg::instWord_t  entries [`PIPE_ISSUE_DEPTH];
    logic [PtrW-1:0]     wrPtr;
    logic [PtrW-1:0]     rdPtr;
    logic [CntW-1:0]     count;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(`PIPE_ISSUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // entry storage
    always_ff @(posedge clk) begin
        if (instValid) begin
            entries[wrPtr] <= instWord;
        end
    end

    // pointers, occupancy and the credit pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (instValid) wrPtr <= nextPtr(wrPtr);
            if (deq) rdPtr <= nextPtr(rdPtr);
            count        <= count + CntW'(instValid) - CntW'(deq);
            creditReturn <= deq;  // one credit per dequeued entry
        end
    end

    assign headValid = (count != '0);
    assign headWord  = entries[rdPtr];

endmodule

//--- verilog/pipePkg.sv
/*
 * Shared types of the ALU pipeline: instruction formats, opcodes,
 * ALU operations, pipeline stage records and forwarding selects.
 */
`include "pipe_config.svh"

package pipePkg;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`PIPE_REG_AW-1:0] rs;
        logic [`PIPE_REG_AW-1:0] rt;
        logic [`PIPE_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rTypeFmt_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`PIPE_REG_AW-1:0] rs;
        logic [`PIPE_REG_AW-1:0] rt;
        logic [15:0]             imm;
    } iTypeFmt_t;

    // same 32 bits, two decodings selected by opcode
    typedef union packed {
        rTypeFmt_t rType;
        iTypeFmt_t iType;
    } instWord_t;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opOri   = 6'h0D;
    localparam logic [5:0] opLui   = 6'h0F;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2A;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui
    } aluOp_t;

    typedef struct packed {
        logic                    valid;
        aluOp_t                  aluOp;
        logic [`PIPE_REG_AW-1:0] rs;
        logic [`PIPE_REG_AW-1:0] rt;
        logic [`PIPE_REG_AW-1:0] dst;
        logic                    wrEn;   // cleared for r0 and no-ops
        logic [`PIPE_DATA_W-1:0] rsData;
        logic [`PIPE_DATA_W-1:0] rtData;
        logic [`PIPE_DATA_W-1:0] imm;    // already extended or shifted
        logic                    useImm;
    } exeStage_t;

    typedef struct packed {
        logic                    valid;
        logic                    wrEn;
        logic [`PIPE_REG_AW-1:0] dst;
        logic [`PIPE_DATA_W-1:0] data;
    } wbInfo_t;

    typedef enum logic [1:0] {
        regFile = 2'd0,
        fromMem = 2'd1,
        fromWb  = 2'd2
    } fwdSel_t;

endpackage

//--- include/pipe_config.svh
/*
 * Global sizing macros for the ALU pipeline.
 * Included by the package and by any module that sizes ports or storage.
 */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

`define PIPE_DATA_W      32  // operand and result width
`define PIPE_REG_AW      5   // register address width
`define PIPE_NUM_REGS    32  // architectural registers

// issue FIFO entries, also the sender's credit count after reset
`define PIPE_ISSUE_DEPTH 4

`endif
